//--- wq_defs.svh
`ifndef WQ_DEFS_SVH
`define WQ_DEFS_SVH

// Queue pair count and index width
`define WQ_NUM_QP 8
`define WQ_QP_W 3

// Datapath widths
`define WQ_IDX_W 16
`define WQ_ADDR_W 64
`define WQ_LEN_W 32
`define WQ_WQE_W 512

// Bit positions of the fields inside a 64-byte WQE
`define WQE_LEN_LSB 96
`define WQE_OP_LSB 128
`define WQE_RADDR_LSB 160

// MTU codes above this are treated as a bad configuration
`define WQ_MTU_MAX_CODE 4

`endif

//--- wq_pkg.sv
`default_nettype none

package wq_pkg;

  // Opcode field of a work-queue element
  typedef enum logic [7:0] {
    WQE_WRITE = 8'h00,
    WQE_SEND  = 8'h02,
    WQE_READ  = 8'h04
  } wqe_op_e;

  // Opcodes of the requests handed to the RDMA engine
  typedef enum logic [4:0] {
    RDMA_WRITE_FIRST  = 5'h06,
    RDMA_WRITE_MIDDLE = 5'h07,
    RDMA_WRITE_LAST   = 5'h08,
    RDMA_WRITE_ONLY   = 5'h0a,
    RDMA_READ_ONLY    = 5'h0c
  } rdma_op_e;

  // MTU in bytes is 256 << code
  typedef logic [2:0] mtu_code_t;

  typedef enum logic [0:0] {DB_IDLE, DB_REQ} db_state_e;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_ADDR, FETCH_READ, FETCH_HOLD} fetch_state_e;

  typedef enum logic [0:0] {SEG_IDLE, SEG_ISSUE} seg_state_e;

endpackage

`default_nettype wire

//--- wqe_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

// Fetch request from the doorbell unit to the WQE fetcher
interface wqe_req_if;
  import wq_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [`WQ_QP_W-1:0]   qp;
  logic [`WQ_ADDR_W-1:0] addr;
  logic [`WQ_ADDR_W-1:0] laddr;
  mtu_code_t             mtu;

  modport src (output valid, output qp, output addr, output laddr, output mtu, input ready);
  modport dst (input valid, input qp, input addr, input laddr, input mtu, output ready);

endinterface

`default_nettype wire

//--- wqe_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

// Decoded WQE from the fetcher to the segmenter
interface wqe_if;
  import wq_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [`WQ_QP_W-1:0]   qp;
  wqe_op_e               opcode;
  logic [`WQ_LEN_W-1:0]  length;
  logic [`WQ_ADDR_W-1:0] raddr;
  logic [`WQ_ADDR_W-1:0] laddr;
  mtu_code_t             mtu;

  modport src (output valid, output qp, output opcode, output length, output raddr,
               output laddr, output mtu, input ready);
  modport dst (input valid, input qp, input opcode, input length, input raddr,
               input laddr, input mtu, output ready);

endinterface

`default_nettype wire

//--- wq_doorbell.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

module wq_doorbell (
  input  logic                  axil_aclk_i,
  input  logic                  rstn_i,
  input  logic                  cfg_we_i,
  input  logic [`WQ_QP_W-1:0]   cfg_qp_i,
  input  logic                  cfg_enable_i,
  input  wq_pkg::mtu_code_t     cfg_mtu_i,
  input  logic [`WQ_ADDR_W-1:0] cfg_sq_base_i,
  input  logic [`WQ_ADDR_W-1:0] cfg_laddr_i,
  input  logic                  db_we_i,
  input  logic [`WQ_QP_W-1:0]   db_qp_i,
  input  logic [`WQ_IDX_W-1:0]  db_prod_idx_i,
  wqe_req_if.src                req
);
  import wq_pkg::*;

  logic                  enable_q    [`WQ_NUM_QP];
  mtu_code_t             mtu_q       [`WQ_NUM_QP];
  logic [`WQ_ADDR_W-1:0] base_q      [`WQ_NUM_QP];
  logic [`WQ_ADDR_W-1:0] laddr_q     [`WQ_NUM_QP];
  logic [`WQ_IDX_W-1:0]  prod_idx_q  [`WQ_NUM_QP];
  logic [`WQ_IDX_W-1:0]  fetch_idx_q [`WQ_NUM_QP];

  logic                  pend_found;
  logic [`WQ_QP_W-1:0]   pend_qp;
  logic [`WQ_ADDR_W-1:0] wqe_offs;

  db_state_e             state_q;
  logic [`WQ_QP_W-1:0]   sel_qp_q;
  logic [`WQ_ADDR_W-1:0] addr_q;
  logic [`WQ_ADDR_W-1:0] req_laddr_q;
  mtu_code_t             req_mtu_q;

  //////////////////////////////////////////////////
  // Per-QP configuration and producer index
  //////////////////////////////////////////////////

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < `WQ_NUM_QP; i++) begin
        enable_q[i]   <= 1'b0;
        prod_idx_q[i] <= '0;
      end
    end else begin
      if (cfg_we_i) begin
        enable_q[cfg_qp_i] <= cfg_enable_i;
      end
      if (db_we_i) begin
        prod_idx_q[db_qp_i] <= db_prod_idx_i;
      end
    end
  end

  always_ff @(posedge axil_aclk_i) begin
    if (cfg_we_i) begin
      mtu_q[cfg_qp_i]   <= cfg_mtu_i;
      base_q[cfg_qp_i]  <= cfg_sq_base_i;
      laddr_q[cfg_qp_i] <= cfg_laddr_i;
    end
  end

  // Lowest-numbered QP with work pending wins
  always_comb begin
    pend_found = 1'b0;
    pend_qp    = '0;
    for (int i = `WQ_NUM_QP - 1; i >= 0; i--) begin
      if (enable_q[i] && (mtu_q[i] <= `WQ_MTU_MAX_CODE) &&
          (prod_idx_q[i] > fetch_idx_q[i])) begin
        pend_found = 1'b1;
        pend_qp    = `WQ_QP_W'(i);
      end
    end
  end

  // WQEs are 64 bytes, so the index lands at bit 6
  assign wqe_offs = {{(`WQ_ADDR_W - `WQ_IDX_W - 6){1'b0}}, fetch_idx_q[pend_qp], 6'b0};

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= DB_IDLE;
      for (int i = 0; i < `WQ_NUM_QP; i++) begin
        fetch_idx_q[i] <= '0;
      end
    end else begin
      case (state_q)
        DB_IDLE: begin
          if (pend_found) begin
            state_q <= DB_REQ;
          end
        end
        DB_REQ: begin
          if (req.ready) begin
            fetch_idx_q[sel_qp_q] <= fetch_idx_q[sel_qp_q] + 1'b1;
            state_q               <= DB_IDLE;
          end
        end
      endcase
    end
  end

  // Payload is frozen while the request waits
  always_ff @(posedge axil_aclk_i) begin
    if (state_q == DB_IDLE && pend_found) begin
      sel_qp_q    <= pend_qp;
      addr_q      <= base_q[pend_qp] + wqe_offs;
      req_laddr_q <= laddr_q[pend_qp];
      req_mtu_q   <= mtu_q[pend_qp];
    end
  end

  assign req.valid = (state_q == DB_REQ);
  assign req.qp    = sel_qp_q;
  assign req.addr  = addr_q;
  assign req.laddr = req_laddr_q;
  assign req.mtu   = req_mtu_q;

endmodule

`default_nettype wire

//--- wq_wqe_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

module wq_wqe_fetch (
  input  logic                  axil_aclk_i,
  input  logic                  rstn_i,
  wqe_req_if.dst                req,
  wqe_if.src                    wqe,
  output logic [`WQ_ADDR_W-1:0] araddr_o,
  output logic                  arvalid_o,
  output logic                  rready_o,
  input  logic                  arready_i,
  input  logic [`WQ_WQE_W-1:0]  rdata_i,
  input  logic                  rlast_i,
  input  logic                  rvalid_i
);
  import wq_pkg::*;

  fetch_state_e          state_q;
  logic [`WQ_WQE_W-1:0]  wqe_buf_q;
  logic [`WQ_QP_W-1:0]   qp_q;
  logic [`WQ_ADDR_W-1:0] laddr_q;
  mtu_code_t             mtu_q;

  // New request only once the buffer has been handed on
  assign req.ready = (state_q == FETCH_IDLE);
  assign arvalid_o = (state_q == FETCH_ADDR);
  assign rready_o  = (state_q == FETCH_READ);

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= FETCH_IDLE;
    end else begin
      case (state_q)
        FETCH_IDLE: if (req.valid) state_q <= FETCH_ADDR;
        FETCH_ADDR: if (arready_i) state_q <= FETCH_READ;
        FETCH_READ: if (rvalid_i && rlast_i) state_q <= FETCH_HOLD;
        FETCH_HOLD: if (wqe.ready) state_q <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge axil_aclk_i) begin
    if (req.valid && req.ready) begin
      araddr_o <= req.addr;
      qp_q     <= req.qp;
      laddr_q  <= req.laddr;
      mtu_q    <= req.mtu;
    end
    if (rvalid_i && rready_o) begin
      wqe_buf_q <= rdata_i;
    end
  end

  // Field extraction from the captured beat
  assign wqe.valid  = (state_q == FETCH_HOLD);
  assign wqe.qp     = qp_q;
  assign wqe.opcode = wqe_op_e'(wqe_buf_q[`WQE_OP_LSB +: 8]);
  assign wqe.length = wqe_buf_q[`WQE_LEN_LSB +: `WQ_LEN_W];
  assign wqe.raddr  = wqe_buf_q[`WQE_RADDR_LSB +: `WQ_ADDR_W];
  assign wqe.laddr  = laddr_q;
  assign wqe.mtu    = mtu_q;

endmodule

`default_nettype wire

//--- wq_segmenter.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

module wq_segmenter (
  input  logic                  axil_aclk_i,
  input  logic                  rstn_i,
  wqe_if.dst                    wqe,
  output logic                  req_valid_o,
  output wq_pkg::rdma_op_e      req_opcode_o,
  output logic [`WQ_QP_W-1:0]   req_qp_o,
  output logic [`WQ_LEN_W-1:0]  req_len_o,
  output logic [`WQ_ADDR_W-1:0] req_laddr_o,
  output logic [`WQ_ADDR_W-1:0] req_raddr_o,
  output logic                  req_last_o,
  input  logic                  req_ready_i
);
  import wq_pkg::*;

  seg_state_e            state_q;
  logic [`WQ_LEN_W-1:0]  mtu_bytes;
  logic [`WQ_LEN_W-1:0]  mtu_bytes_q;
  logic [`WQ_ADDR_W-1:0] mtu_step;
  logic [`WQ_LEN_W-1:0]  remain_q;
  logic                  wqe_fire;
  logic                  wqe_keep;
  logic                  req_fire;

  assign mtu_bytes = `WQ_LEN_W'(256) << wqe.mtu;
  assign mtu_step  = `WQ_ADDR_W'(mtu_bytes_q);

  assign wqe.ready   = (state_q == SEG_IDLE);
  assign wqe_fire    = wqe.valid && wqe.ready;
  assign req_valid_o = (state_q == SEG_ISSUE);
  assign req_fire    = req_valid_o && req_ready_i;

  // SEND and unknown opcodes are taken off the interface and dropped
  assign wqe_keep = (wqe.opcode == WQE_WRITE) || (wqe.opcode == WQE_READ);

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= SEG_IDLE;
    end else begin
      case (state_q)
        SEG_IDLE: begin
          if (wqe_fire && wqe_keep) begin
            state_q <= SEG_ISSUE;
          end
        end
        SEG_ISSUE: begin
          if (req_fire && req_last_o) begin
            state_q <= SEG_IDLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Segment generation
  //////////////////////////////////////////////////

  always_ff @(posedge axil_aclk_i) begin
    if (wqe_fire) begin
      req_qp_o    <= wqe.qp;
      req_laddr_o <= wqe.laddr;
      req_raddr_o <= wqe.raddr;
      mtu_bytes_q <= mtu_bytes;
      if (wqe.opcode == WQE_READ) begin
        req_opcode_o <= RDMA_READ_ONLY;
        req_len_o    <= wqe.length;
        req_last_o   <= 1'b1;
      end else if (wqe.length <= mtu_bytes) begin
        // Fits in one packet
        req_opcode_o <= RDMA_WRITE_ONLY;
        req_len_o    <= wqe.length;
        req_last_o   <= 1'b1;
      end else begin
        req_opcode_o <= RDMA_WRITE_FIRST;
        req_len_o    <= mtu_bytes;
        req_last_o   <= 1'b0;
        remain_q     <= wqe.length - mtu_bytes;
      end
    end else if (req_fire && !req_last_o) begin
      // Step both addresses past the accepted segment
      req_laddr_o <= req_laddr_o + mtu_step;
      req_raddr_o <= req_raddr_o + mtu_step;
      if (remain_q <= mtu_bytes_q) begin
        req_opcode_o <= RDMA_WRITE_LAST;
        req_len_o    <= remain_q;
        req_last_o   <= 1'b1;
      end else begin
        req_opcode_o <= RDMA_WRITE_MIDDLE;
        req_len_o    <= mtu_bytes_q;
        req_last_o   <= 1'b0;
        remain_q     <= remain_q - mtu_bytes_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- wq_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

module wq_manager (
  input  logic                  axil_aclk_i,
  input  logic                  rstn_i,
  // Configuration
  input  logic                  cfg_we_i,
  input  logic [`WQ_QP_W-1:0]   cfg_qp_i,
  input  logic                  cfg_enable_i,
  input  wq_pkg::mtu_code_t     cfg_mtu_i,
  input  logic [`WQ_ADDR_W-1:0] cfg_sq_base_i,
  input  logic [`WQ_ADDR_W-1:0] cfg_laddr_i,
  // Doorbell
  input  logic                  db_we_i,
  input  logic [`WQ_QP_W-1:0]   db_qp_i,
  input  logic [`WQ_IDX_W-1:0]  db_prod_idx_i,
  // AXI4 read channel
  output logic [`WQ_ADDR_W-1:0] araddr_o,
  output logic [7:0]            arlen_o,
  output logic [2:0]            arsize_o,
  output logic [1:0]            arburst_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  logic [`WQ_WQE_W-1:0]  rdata_i,
  input  logic                  rlast_i,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  // RDMA requests
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output wq_pkg::rdma_op_e      req_opcode_o,
  output logic [`WQ_QP_W-1:0]   req_qp_o,
  output logic [`WQ_LEN_W-1:0]  req_len_o,
  output logic [`WQ_ADDR_W-1:0] req_laddr_o,
  output logic [`WQ_ADDR_W-1:0] req_raddr_o,
  output logic                  req_last_o
);

  wqe_req_if req_if ();
  wqe_if     wqe_bus ();

  // Single 64-byte beat per WQE
  assign arlen_o   = 8'd0;
  assign arsize_o  = 3'd6;
  assign arburst_o = 2'b01;

  wq_doorbell u_doorbell (
    .axil_aclk_i   (axil_aclk_i),
    .rstn_i        (rstn_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_qp_i      (cfg_qp_i),
    .cfg_enable_i  (cfg_enable_i),
    .cfg_mtu_i     (cfg_mtu_i),
    .cfg_sq_base_i (cfg_sq_base_i),
    .cfg_laddr_i   (cfg_laddr_i),
    .db_we_i       (db_we_i),
    .db_qp_i       (db_qp_i),
    .db_prod_idx_i (db_prod_idx_i),
    .req           (req_if.src)
  );

  wq_wqe_fetch u_fetch (
    .axil_aclk_i (axil_aclk_i),
    .rstn_i      (rstn_i),
    .req         (req_if.dst),
    .wqe         (wqe_bus.src),
    .araddr_o    (araddr_o),
    .arvalid_o   (arvalid_o),
    .rready_o    (rready_o),
    .arready_i   (arready_i),
    .rdata_i     (rdata_i),
    .rlast_i     (rlast_i),
    .rvalid_i    (rvalid_i)
  );

  wq_segmenter u_segmenter (
    .axil_aclk_i  (axil_aclk_i),
    .rstn_i       (rstn_i),
    .wqe          (wqe_bus.dst),
    .req_valid_o  (req_valid_o),
    .req_opcode_o (req_opcode_o),
    .req_qp_o     (req_qp_o),
    .req_len_o    (req_len_o),
    .req_laddr_o  (req_laddr_o),
    .req_raddr_o  (req_raddr_o),
    .req_last_o   (req_last_o),
    .req_ready_i  (req_ready_i)
  );

endmodule

`default_nettype wire

//--- tb_wq_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

module tb_wq_assert (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  arvalid_i,
  input  logic                  arready_i,
  input  logic [`WQ_ADDR_W-1:0] araddr_i,
  input  logic [7:0]            arlen_i,
  input  logic [2:0]            arsize_i,
  input  logic [1:0]            arburst_i,
  input  logic                  rready_i,
  input  logic                  req_valid_i,
  input  logic                  req_ready_i,
  input  wq_pkg::rdma_op_e      req_opcode_i,
  input  logic [`WQ_QP_W-1:0]   req_qp_i,
  input  logic [`WQ_LEN_W-1:0]  req_len_i,
  input  logic [`WQ_ADDR_W-1:0] req_laddr_i,
  input  logic [`WQ_ADDR_W-1:0] req_raddr_i,
  input  logic                  req_last_i
);

  int fail_cnt = 0;

  // Read address held until the slave takes it
  ar_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      fail_cnt++;
      $error("araddr changed or arvalid dropped before arready");
    end

  // One 64-byte INCR beat per WQE
  ar_attr: assert property (@(posedge clk_i) disable iff (!rstn_i)
    arvalid_i |-> (arlen_i == 8'd0) && (arsize_i == 3'd6) && (arburst_i == 2'b01))
    else begin
      fail_cnt++;
      $error("AR attributes differ from a single 64-byte INCR beat");
    end

  // Read data channel opens right after the address handshake
  r_after_ar: assert property (@(posedge clk_i) disable iff (!rstn_i)
    arvalid_i && arready_i |=> rready_i)
    else begin
      fail_cnt++;
      $error("rready not raised after the AR handshake");
    end

  // Request payload frozen under back-pressure
  req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_valid_i && !req_ready_i |=> req_valid_i &&
      $stable({req_opcode_i, req_qp_i, req_len_i, req_laddr_i, req_raddr_i, req_last_i}))
    else begin
      fail_cnt++;
      $error("request dropped or changed while stalled");
    end

  req_len_nz: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_valid_i |-> req_len_i != '0)
    else begin
      fail_cnt++;
      $error("request with zero length");
    end

endmodule

`default_nettype wire

//--- tb_wq_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "wq_defs.svh"

module tb_wq_manager;
  import wq_pkg::*;

  localparam int WAIT_CYCLES = 2000;

  typedef struct packed {
    logic [4:0]            op;
    logic [`WQ_QP_W-1:0]   qp;
    logic [`WQ_LEN_W-1:0]  len;
    logic [`WQ_ADDR_W-1:0] laddr;
    logic [`WQ_ADDR_W-1:0] raddr;
    logic                  last;
  } req_t;

  logic                  axil_aclk_i;
  logic                  rstn_i;
  logic                  cfg_we_i;
  logic [`WQ_QP_W-1:0]   cfg_qp_i;
  logic                  cfg_enable_i;
  mtu_code_t             cfg_mtu_i;
  logic [`WQ_ADDR_W-1:0] cfg_sq_base_i;
  logic [`WQ_ADDR_W-1:0] cfg_laddr_i;
  logic                  db_we_i;
  logic [`WQ_QP_W-1:0]   db_qp_i;
  logic [`WQ_IDX_W-1:0]  db_prod_idx_i;
  logic [`WQ_ADDR_W-1:0] araddr_o;
  logic [7:0]            arlen_o;
  logic [2:0]            arsize_o;
  logic [1:0]            arburst_o;
  logic                  arvalid_o;
  logic                  arready_i = 1'b0;
  logic [`WQ_WQE_W-1:0]  rdata_i = '0;
  logic                  rlast_i = 1'b0;
  logic                  rvalid_i = 1'b0;
  logic                  rready_o;
  logic                  req_valid_o;
  logic                  req_ready_i = 1'b0;
  rdma_op_e              req_opcode_o;
  logic [`WQ_QP_W-1:0]   req_qp_o;
  logic [`WQ_LEN_W-1:0]  req_len_o;
  logic [`WQ_ADDR_W-1:0] req_laddr_o;
  logic [`WQ_ADDR_W-1:0] req_raddr_o;
  logic                  req_last_o;

  logic [`WQ_WQE_W-1:0]  mem [logic [`WQ_ADDR_W-1:0]];
  logic [`WQ_ADDR_W-1:0] qp_base  [`WQ_NUM_QP];
  logic [`WQ_ADDR_W-1:0] qp_laddr [`WQ_NUM_QP];
  logic [2:0]            qp_mtu   [`WQ_NUM_QP];
  req_t                  exp_q [$];
  req_t                  rec_q [$];
  logic [`WQ_ADDR_W-1:0] exp_rd_q [$];
  logic [`WQ_ADDR_W-1:0] rd_q [$];
  int                    err_cnt = 0;
  int                    err_mark = 0;
  int                    tests_ok = 0;
  int                    tests_bad = 0;

  wq_manager DUT (.*);

  bind wq_manager tb_wq_assert u_assert (
    .clk_i (axil_aclk_i), .rstn_i (rstn_i), .arvalid_i (arvalid_o), .arready_i (arready_i),
    .araddr_i (araddr_o), .arlen_i (arlen_o), .arsize_i (arsize_o), .arburst_i (arburst_o),
    .rready_i (rready_o), .req_valid_i (req_valid_o), .req_ready_i (req_ready_i),
    .req_opcode_i (req_opcode_o), .req_qp_i (req_qp_o), .req_len_i (req_len_o),
    .req_laddr_i (req_laddr_o), .req_raddr_i (req_raddr_o), .req_last_i (req_last_o)
  );

  initial begin
    axil_aclk_i = 1'b0;
    forever #5 axil_aclk_i = ~axil_aclk_i;
  end

  //////////////////////////////////////////////////
  // AXI memory model and request sink
  //////////////////////////////////////////////////

  int                    ar_dly = 0;
  int                    rd_dly = 0;
  logic                  rd_busy = 1'b0;
  logic [`WQ_ADDR_W-1:0] rd_addr = '0;

  // Unwritten locations return a pattern built from the full address
  function automatic logic [`WQ_WQE_W-1:0] mem_read(input logic [`WQ_ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {8{a}};
  endfunction

  always @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      arready_i <= 1'b0;
      rvalid_i  <= 1'b0;
      rlast_i   <= 1'b0;
      rd_busy   <= 1'b0;
      ar_dly    <= 0;
    end else begin
      if (arvalid_o && arready_i) begin
        arready_i <= 1'b0;
        rd_addr   <= araddr_o;
        rd_busy   <= 1'b1;
        rd_dly    <= $urandom_range(0, 4);
        rd_q.push_back(araddr_o);
      end else if (arvalid_o && !rd_busy) begin
        if (ar_dly == 0) begin
          arready_i <= 1'b1;
        end else begin
          ar_dly <= ar_dly - 1;
        end
      end
      if (rvalid_i && rready_o) begin
        rvalid_i <= 1'b0;
        rlast_i  <= 1'b0;
        rd_busy  <= 1'b0;
        ar_dly   <= $urandom_range(0, 3);
      end else if (rd_busy && !rvalid_i) begin
        if (rd_dly == 0) begin
          rvalid_i <= 1'b1;
          rlast_i  <= 1'b1;
          rdata_i  <= mem_read(rd_addr);
        end else begin
          rd_dly <= rd_dly - 1;
        end
      end
    end
  end

  always @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      req_ready_i <= 1'b0;
    end else begin
      req_ready_i <= ($urandom_range(0, 3) != 0);
      if (req_valid_o && req_ready_i) begin
        rec_q.push_back({5'(req_opcode_o), req_qp_o, req_len_o, req_laddr_o, req_raddr_o,
                         req_last_o});
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic configure_qp(input int qp, input logic en, input logic [2:0] mtu,
                              input logic [63:0] base, input logic [63:0] laddr);
    qp_base[qp]  = base;
    qp_laddr[qp] = laddr;
    qp_mtu[qp]   = mtu;
    @(posedge axil_aclk_i);
    cfg_we_i      <= 1'b1;
    cfg_qp_i      <= qp[`WQ_QP_W-1:0];
    cfg_enable_i  <= en;
    cfg_mtu_i     <= mtu;
    cfg_sq_base_i <= base;
    cfg_laddr_i   <= laddr;
    @(posedge axil_aclk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic ring_doorbell(input int qp, input int prod_idx);
    @(posedge axil_aclk_i);
    db_we_i       <= 1'b1;
    db_qp_i       <= qp[`WQ_QP_W-1:0];
    db_prod_idx_i <= prod_idx[`WQ_IDX_W-1:0];
    @(posedge axil_aclk_i);
    db_we_i <= 1'b0;
  endtask

  // Expected requests follow the MTU split rule
  task automatic expect_wqe(input logic [7:0] op, input int qp, input logic [31:0] len,
                            input logic [63:0] raddr);
    logic [31:0] mtu_b;
    logic [31:0] left;
    logic [63:0] off;
    req_t        r;
    mtu_b   = 32'd256 << qp_mtu[qp];
    r.qp    = qp[`WQ_QP_W-1:0];
    r.laddr = qp_laddr[qp];
    r.raddr = raddr;
    r.len   = len;
    r.last  = 1'b1;
    if (op == WQE_READ) begin
      r.op = RDMA_READ_ONLY;
      exp_q.push_back(r);
    end else if (op == WQE_WRITE && len <= mtu_b) begin
      r.op = RDMA_WRITE_ONLY;
      exp_q.push_back(r);
    end else if (op == WQE_WRITE) begin
      left = len;
      off  = '0;
      while (left > 0) begin
        r.len   = (left > mtu_b) ? mtu_b : left;
        r.last  = (left <= mtu_b);
        r.op    = (off == 0) ? RDMA_WRITE_FIRST : (r.last ? RDMA_WRITE_LAST : RDMA_WRITE_MIDDLE);
        r.laddr = qp_laddr[qp] + off;
        r.raddr = raddr + off;
        exp_q.push_back(r);
        left = left - r.len;
        off  = off + mtu_b;
      end
    end
  endtask

  task automatic post_wqe(input int qp, input int idx, input logic [7:0] op,
                          input logic [31:0] len, input logic [63:0] raddr);
    logic [`WQ_WQE_W-1:0]  w;
    logic [`WQ_ADDR_W-1:0] a;
    a = qp_base[qp] + (64'(idx) << 6);
    w = {16{32'h5aa5_0ff0}};
    w[`WQE_OP_LSB +: 8]             = op;
    w[`WQE_LEN_LSB +: `WQ_LEN_W]    = len;
    w[`WQE_RADDR_LSB +: `WQ_ADDR_W] = raddr;
    mem[a] = w;
    exp_rd_q.push_back(a);
    expect_wqe(op, qp, len, raddr);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_requests();
    int   waited;
    req_t e;
    req_t g;
    waited = 0;
    while (rec_q.size() < exp_q.size() && waited < WAIT_CYCLES) begin
      @(negedge axil_aclk_i);
      waited++;
    end
    if (rec_q.size() < exp_q.size()) begin
      $display("ERROR t=%0t timed out with %0d of %0d requests received", $time,
               rec_q.size(), exp_q.size());
      err_cnt++;
    end
    while (exp_q.size() > 0 && rec_q.size() > 0) begin
      e = exp_q.pop_front();
      g = rec_q.pop_front();
      check_val("req_opcode_o", e.op, g.op);
      check_val("req_qp_o", e.qp, g.qp);
      check_val("req_len_o", e.len, g.len);
      check_val("req_laddr_o", e.laddr, g.laddr);
      check_val("req_raddr_o", e.raddr, g.raddr);
      check_val("req_last_o", e.last, g.last);
    end
    if (rec_q.size() != 0) begin
      $display("ERROR t=%0t %0d requests arrived that were not expected", $time, rec_q.size());
      err_cnt++;
    end
    if (rd_q.size() != exp_rd_q.size()) begin
      $display("ERROR t=%0t saw %0d reads where %0d were expected", $time,
               rd_q.size(), exp_rd_q.size());
      err_cnt++;
    end
    while (rd_q.size() > 0 && exp_rd_q.size() > 0) begin
      check_val("araddr_o", exp_rd_q.pop_front(), rd_q.pop_front());
    end
    exp_q.delete();
    rec_q.delete();
    rd_q.delete();
    exp_rd_q.delete();
  endtask

  task automatic end_test(input string name);
    if (err_cnt > err_mark) begin
      $display("Test %s: FAIL with %0d errors", name, err_cnt - err_mark);
      tests_bad++;
    end else begin
      $display("Test %s: ok", name);
      tests_ok++;
    end
    err_mark = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int total;
    void'($urandom(32'hb6980fb9));
    rstn_i        = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_qp_i      = '0;
    cfg_enable_i  = 1'b0;
    cfg_mtu_i     = '0;
    cfg_sq_base_i = '0;
    cfg_laddr_i   = '0;
    db_we_i       = 1'b0;
    db_qp_i       = '0;
    db_prod_idx_i = '0;
    repeat (10) @(posedge axil_aclk_i);
    rstn_i <= 1'b1;

    // Configuration alone must not start any traffic
    configure_qp(0, 1'b1, 3'd0, 64'h0000_0001_0000_0000, 64'h0000_00a0_0000_0000);
    configure_qp(1, 1'b1, 3'd1, 64'h0000_0002_0000_0400, 64'h0000_00b0_0000_0100);
    configure_qp(2, 1'b0, 3'd0, 64'h0000_0003_0000_0000, 64'h0000_00c0_0000_0000);
    configure_qp(3, 1'b1, 3'd5, 64'h0000_0004_0000_0000, 64'h0000_00d0_0000_0000);
    for (int c = 0; c < 20; c++) begin
      @(negedge axil_aclk_i);
      check_val("arvalid_o", 1'b0, arvalid_o);
      check_val("rready_o", 1'b0, rready_o);
      check_val("req_valid_o", 1'b0, req_valid_o);
    end
    end_test("reset_idle");

    post_wqe(0, 0, WQE_WRITE, 32'd200, 64'h0000_0050_0000_0000);
    ring_doorbell(0, 1);
    check_requests();
    end_test("write_only");

    post_wqe(1, 0, WQE_WRITE, 32'd1800, 64'h0000_0060_0000_0040);
    post_wqe(1, 1, WQE_WRITE, 32'd1024, 64'h0000_0061_0000_0000);
    ring_doorbell(1, 2);
    check_requests();
    end_test("write_segmented");

    post_wqe(0, 1, WQE_READ, 32'd5000, 64'h0000_0070_0000_0000);
    post_wqe(0, 2, WQE_SEND, 32'd64, 64'h0000_0071_0000_0000);
    post_wqe(0, 3, WQE_WRITE, 32'd256, 64'h0000_0072_0000_0000);
    ring_doorbell(0, 4);
    check_requests();
    end_test("read_and_send");

    // Disabled QP and bad MTU code
    ring_doorbell(2, 1);
    ring_doorbell(3, 1);
    for (int c = 0; c < 300; c++) begin
      @(negedge axil_aclk_i);
      if (arvalid_o) begin
        $display("ERROR t=%0t read issued for a QP that must stay blocked", $time);
        err_cnt++;
        break;
      end
    end
    check_requests();
    end_test("blocked_qp");

    total = err_cnt + DUT.u_assert.fail_cnt;
    $display("Summary: %0d tests ok, %0d tests failed, %0d check errors, %0d assertion failures",
             tests_ok, tests_bad, err_cnt, DUT.u_assert.fail_cnt);
    if (total == 0 && tests_bad == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
wq_pkg.sv
wqe_req_if.sv
wqe_if.sv
wq_doorbell.sv
wq_wqe_fetch.sv
wq_segmenter.sv
wq_manager.sv
tb_wq_assert.sv
tb_wq_manager.sv

//--- Bender.yml
package:
  name: wq_manager

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wq_pkg.sv
      - wqe_req_if.sv
      - wqe_if.sv
      - wq_doorbell.sv
      - wq_wqe_fetch.sv
      - wq_segmenter.sv
      - wq_manager.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wq_assert.sv
      - tb_wq_manager.sv
